/* decoder_riscv.f */
hdl/decoder_pkg.sv
hdl/opcode_classify.sv
hdl/alu_op_decode.sv
hdl/mem_access_decode.sv
hdl/system_decode.sv
hdl/ctrl_word_gen.sv
hdl/decoder_riscv.sv
testbench/decoder_chk.sv
testbench/tb_decoder_riscv.sv

/* hdl/alu_op_decode.sv */
`timescale 1ns/1ps

module alu_op_decode
  import decoder_pkg::*;
(
  input  instr_t       instr_i,
  input  instr_class_e class_i,
  output alu_dec_t     alu_dec_o
);

  funct3_t funct3;
  funct7_t funct7;
  logic    shift_op;

  assign funct3   = instr_i[14:12];
  assign funct7   = instr_i[31:25];
  assign shift_op = (funct3 == 3'b001) || (funct3 == 3'b101);

  // Shared by register and immediate forms, alt picks SUB or SRA
  function automatic alu_op_e arith_op(input funct3_t f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLTS;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  always_comb
  begin
    alu_dec_o.alu_op = ALU_ADD;
    alu_dec_o.legal  = 1'b1;
    case (class_i)
      CLASS_OP:
      begin
        alu_dec_o.alu_op = arith_op(funct3, funct7 == FUNCT7_ALT);
        alu_dec_o.legal  = (funct7 == FUNCT7_BASE) ||
                           ((funct7 == FUNCT7_ALT) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      CLASS_OP_IMM:
      begin
        // Upper immediate bits are only an encoding field for shifts
        alu_dec_o.alu_op = arith_op(funct3, (funct3 == 3'b101) && (funct7 == FUNCT7_ALT));
        if (shift_op)
        begin
          alu_dec_o.legal = (funct7 == FUNCT7_BASE) ||
                            ((funct3 == 3'b101) && (funct7 == FUNCT7_ALT));
        end
      end
      CLASS_BRANCH:
      begin
        case (funct3)
          3'b000:  alu_dec_o.alu_op = ALU_EQ;
          3'b001:  alu_dec_o.alu_op = ALU_NE;
          3'b100:  alu_dec_o.alu_op = ALU_LTS;
          3'b101:  alu_dec_o.alu_op = ALU_GES;
          3'b110:  alu_dec_o.alu_op = ALU_LTU;
          3'b111:  alu_dec_o.alu_op = ALU_GEU;
          default: alu_dec_o.legal  = 1'b0;  // funct3 2 and 3
        endcase
      end
      default:
      begin
        alu_dec_o.alu_op = ALU_ADD;
      end
    endcase
  end

endmodule

/* hdl/ctrl_word_gen.sv */
`timescale 1ns/1ps

module ctrl_word_gen
  import decoder_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         stall_i,
  input  logic         interrupt_i,
  input  instr_class_e class_i,
  input  instr_t       instr_i,
  input  alu_dec_t     alu_dec_i,
  input  mem_dec_t     mem_dec_i,
  input  sys_dec_t     sys_dec_i,
  output decode_ctrl_t ctrl_o,
  output logic         illegal_instr_o
);

  funct3_t      funct3;
  decode_ctrl_t ctrl_dec;
  decode_ctrl_t ctrl_trap;
  decode_ctrl_t ctrl_next;
  logic         illegal;

  assign funct3 = instr_i[14:12];

  always_comb
  begin
    ctrl_dec = CTRL_BUBBLE;
    case (class_i)
      CLASS_OP, CLASS_OP_IMM:
      begin
        ctrl_dec.op_b_sel = (class_i == CLASS_OP) ? OP_B_RS2 : OP_B_IMM_I;
        ctrl_dec.alu_op   = alu_dec_i.alu_op;
        ctrl_dec.gpr_we   = 1'b1;
      end
      CLASS_LOAD:
      begin
        ctrl_dec.op_b_sel   = OP_B_IMM_I;
        ctrl_dec.alu_op     = ALU_ADD;  // Address = rs1 + imm
        ctrl_dec.mem_req    = 1'b1;
        ctrl_dec.mem_size   = mem_dec_i.mem_size;
        ctrl_dec.wb_src_sel = 1'b1;
        ctrl_dec.gpr_we     = 1'b1;
      end
      CLASS_STORE:
      begin
        ctrl_dec.op_b_sel = OP_B_IMM_S;
        ctrl_dec.alu_op   = ALU_ADD;
        ctrl_dec.mem_req  = 1'b1;
        ctrl_dec.mem_we   = 1'b1;
        ctrl_dec.mem_size = mem_dec_i.mem_size;
      end
      CLASS_BRANCH:
      begin
        ctrl_dec.alu_op = alu_dec_i.alu_op;  // Compare rs1 with rs2
        ctrl_dec.branch = 1'b1;
      end
      CLASS_JAL, CLASS_JALR:
      begin
        ctrl_dec.op_a_sel = OP_A_PC;  // Link value pc + 4
        ctrl_dec.op_b_sel = OP_B_INCR4;
        ctrl_dec.alu_op   = ALU_ADD;
        ctrl_dec.gpr_we   = 1'b1;
        ctrl_dec.jal      = (class_i == CLASS_JAL);
        ctrl_dec.jalr_sel = (class_i == CLASS_JALR) ? JALR_JALR : JALR_NONE;
      end
      CLASS_LUI, CLASS_AUIPC:
      begin
        ctrl_dec.op_a_sel = (class_i == CLASS_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl_dec.op_b_sel = OP_B_IMM_U;
        ctrl_dec.alu_op   = ALU_ADD;
        ctrl_dec.gpr_we   = 1'b1;
      end
      CLASS_SYSTEM:
      begin
        ctrl_dec.csr      = sys_dec_i.csr;
        ctrl_dec.csr_op   = sys_dec_i.csr_op;
        ctrl_dec.gpr_we   = sys_dec_i.gpr_we;
        ctrl_dec.jalr_sel = sys_dec_i.jalr_sel;
        ctrl_dec.int_rst  = sys_dec_i.int_rst;
      end
      default:
      begin
        ctrl_dec = CTRL_BUBBLE;  // FENCE and invalid
      end
    endcase
  end

  assign illegal = (class_i == CLASS_INVALID) ||
                   ((class_i == CLASS_JALR) && (funct3 != 3'b000)) ||
                   !alu_dec_i.legal || !mem_dec_i.legal || !sys_dec_i.legal;

  always_comb
  begin
    ctrl_trap          = CTRL_BUBBLE;
    ctrl_trap.csr      = 1'b1;
    ctrl_trap.csr_op   = CSR_OP_TRAP;
    ctrl_trap.jalr_sel = JALR_TRAP;
    if (interrupt_i)
    begin
      ctrl_next = ctrl_trap;  // Interrupt wins over any encoding
    end
    else if (illegal)
    begin
      ctrl_next = CTRL_BUBBLE;
    end
    else
    begin
      ctrl_next = ctrl_dec;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_o          <= CTRL_BUBBLE;
      illegal_instr_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      ctrl_o          <= ctrl_next;
      illegal_instr_o <= illegal && !interrupt_i;
    end
  end

endmodule

/* hdl/decoder_pkg.sv */
package decoder_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  opcode_t;    // instr[6:2]
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [2:0]  csr_op_t;

  localparam opcode_t OPC_LOAD     = 5'b00000;
  localparam opcode_t OPC_MISC_MEM = 5'b00011;
  localparam opcode_t OPC_OP_IMM   = 5'b00100;
  localparam opcode_t OPC_AUIPC    = 5'b00101;
  localparam opcode_t OPC_STORE    = 5'b01000;
  localparam opcode_t OPC_OP       = 5'b01100;
  localparam opcode_t OPC_LUI      = 5'b01101;
  localparam opcode_t OPC_BRANCH   = 5'b11000;
  localparam opcode_t OPC_JALR     = 5'b11001;
  localparam opcode_t OPC_JAL      = 5'b11011;
  localparam opcode_t OPC_SYSTEM   = 5'b11100;

  localparam logic [1:0] QUADRANT_32 = 2'b11;  // Uncompressed encodings only

  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000;  // SUB and SRA/SRAI

  localparam csr_op_t CSR_OP_TRAP = 3'b100;

  typedef enum logic [3:0] {
    CLASS_OP,
    CLASS_OP_IMM,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_BRANCH,
    CLASS_JAL,
    CLASS_JALR,
    CLASS_LUI,
    CLASS_AUIPC,
    CLASS_SYSTEM,
    CLASS_MISC_MEM,
    CLASS_INVALID
  } instr_class_e;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLTS = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    ALU_EQ   = 5'b11000,
    ALU_NE   = 5'b11001,
    ALU_LTS  = 5'b11100,
    ALU_GES  = 5'b11101,
    ALU_LTU  = 5'b11110,
    ALU_GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_RS1 = 2'd0, OP_A_PC = 2'd1, OP_A_ZERO = 2'd2} op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_RS2   = 3'd0,
    OP_B_IMM_I = 3'd1,
    OP_B_IMM_U = 3'd2,
    OP_B_IMM_S = 3'd3,
    OP_B_INCR4 = 3'd4
  } op_b_sel_e;

  typedef enum logic [2:0] {
    MEM_BYTE  = 3'd0,
    MEM_HALF  = 3'd1,
    MEM_WORD  = 3'd2,
    MEM_UBYTE = 3'd4,
    MEM_UHALF = 3'd5
  } mem_size_e;

  typedef enum logic [1:0] {
    JALR_NONE = 2'd0,
    JALR_JALR = 2'd1,
    JALR_MRET = 2'd2,  // Return to mepc
    JALR_TRAP = 2'd3   // Jump to mtvec
  } jalr_sel_e;

  typedef struct packed {
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    alu_op_e   alu_op;
    logic      mem_req;
    logic      mem_we;
    mem_size_e mem_size;
    logic      gpr_we;
    logic      wb_src_sel;  // 1 selects load data
    logic      branch;
    logic      jal;
    jalr_sel_e jalr_sel;
    logic      csr;
    csr_op_t   csr_op;
    logic      int_rst;
  } decode_ctrl_t;

  localparam decode_ctrl_t CTRL_BUBBLE = '0;

  typedef struct packed {
    alu_op_e alu_op;
    logic    legal;
  } alu_dec_t;

  typedef struct packed {
    mem_size_e mem_size;
    logic      legal;
  } mem_dec_t;

  typedef struct packed {
    logic      csr;
    csr_op_t   csr_op;
    logic      gpr_we;
    jalr_sel_e jalr_sel;
    logic      int_rst;
    logic      legal;
  } sys_dec_t;

endpackage

/* hdl/decoder_riscv.sv */
`timescale 1ns/1ps

module decoder_riscv
  import decoder_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  instr_t       instr_i,
  input  logic         stall_i,
  input  logic         interrupt_i,
  output decode_ctrl_t ctrl_o,
  output logic         illegal_instr_o
);

  instr_class_e instr_class;
  alu_dec_t     alu_dec;
  mem_dec_t     mem_dec;
  sys_dec_t     sys_dec;

  opcode_classify u_classify (
    .instr_i (instr_i),
    .class_o (instr_class)
  );

  alu_op_decode u_alu_dec (
    .instr_i   (instr_i),
    .class_i   (instr_class),
    .alu_dec_o (alu_dec)
  );

  mem_access_decode u_mem_dec (
    .instr_i   (instr_i),
    .class_i   (instr_class),
    .mem_dec_o (mem_dec)
  );

  system_decode u_sys_dec (
    .instr_i   (instr_i),
    .class_i   (instr_class),
    .sys_dec_o (sys_dec)
  );

  ctrl_word_gen u_ctrl_gen (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .stall_i         (stall_i),
    .interrupt_i     (interrupt_i),
    .class_i         (instr_class),
    .instr_i         (instr_i),
    .alu_dec_i       (alu_dec),
    .mem_dec_i       (mem_dec),
    .sys_dec_i       (sys_dec),
    .ctrl_o          (ctrl_o),
    .illegal_instr_o (illegal_instr_o)
  );

endmodule

/* hdl/mem_access_decode.sv */
`timescale 1ns/1ps

module mem_access_decode
  import decoder_pkg::*;
(
  input  instr_t       instr_i,
  input  instr_class_e class_i,
  output mem_dec_t     mem_dec_o
);

  funct3_t funct3;
  logic    size_ok;

  assign funct3 = instr_i[14:12];

  always_comb
  begin
    case (class_i)
      CLASS_LOAD:
      begin
        size_ok = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
      end
      CLASS_STORE:
      begin
        size_ok = (funct3 <= 3'b010);  // No unsigned stores
      end
      default:
      begin
        size_ok = 1'b1;
      end
    endcase
  end

  always_comb
  begin
    mem_dec_o.legal    = size_ok;
    mem_dec_o.mem_size = MEM_BYTE;
    if (size_ok && (class_i == CLASS_LOAD || class_i == CLASS_STORE))
    begin
      mem_dec_o.mem_size = mem_size_e'(funct3);  // Size code is funct3
    end
  end

endmodule

/* hdl/opcode_classify.sv */
`timescale 1ns/1ps

module opcode_classify
  import decoder_pkg::*;
(
  input  instr_t       instr_i,
  output instr_class_e class_o
);

  opcode_t opcode;

  assign opcode = instr_i[6:2];

  always_comb
  begin
    if (instr_i[1:0] != QUADRANT_32)
    begin
      class_o = CLASS_INVALID;  // Compressed or reserved quadrant
    end
    else
    begin
      case (opcode)
        OPC_OP:       class_o = CLASS_OP;
        OPC_OP_IMM:   class_o = CLASS_OP_IMM;
        OPC_LOAD:     class_o = CLASS_LOAD;
        OPC_STORE:    class_o = CLASS_STORE;
        OPC_BRANCH:   class_o = CLASS_BRANCH;
        OPC_JAL:      class_o = CLASS_JAL;
        OPC_JALR:     class_o = CLASS_JALR;
        OPC_LUI:      class_o = CLASS_LUI;
        OPC_AUIPC:    class_o = CLASS_AUIPC;
        OPC_SYSTEM:   class_o = CLASS_SYSTEM;
        OPC_MISC_MEM: class_o = CLASS_MISC_MEM;  // FENCE
        default:      class_o = CLASS_INVALID;
      endcase
    end
  end

endmodule

/* hdl/system_decode.sv */
`timescale 1ns/1ps

module system_decode
  import decoder_pkg::*;
(
  input  instr_t       instr_i,
  input  instr_class_e class_i,
  output sys_dec_t     sys_dec_o
);

  funct3_t funct3;

  assign funct3 = instr_i[14:12];

  always_comb
  begin
    sys_dec_o.csr      = 1'b0;
    sys_dec_o.csr_op   = '0;
    sys_dec_o.gpr_we   = 1'b0;
    sys_dec_o.jalr_sel = JALR_NONE;
    sys_dec_o.int_rst  = 1'b0;
    sys_dec_o.legal    = 1'b1;
    if (class_i == CLASS_SYSTEM)
    begin
      case (funct3)
        3'b000:
        begin
          sys_dec_o.jalr_sel = JALR_MRET;  // MRET
          sys_dec_o.int_rst  = 1'b1;
        end
        3'b001, 3'b010, 3'b011:
        begin
          sys_dec_o.csr    = 1'b1;  // CSRRW, CSRRS, CSRRC
          sys_dec_o.csr_op = funct3;
          sys_dec_o.gpr_we = 1'b1;
        end
        default:
        begin
          sys_dec_o.legal = 1'b0;  // Immediate CSR forms
        end
      endcase
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the decoder testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_decoder_riscv -f decoder_riscv.f \
  && ./obj_dir/Vtb_decoder_riscv | tee /dev/stderr | grep -qx '>>> PASS' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0

/* testbench/decoder_chk.sv */
`timescale 1ns/1ps

module decoder_chk
  import decoder_pkg::*;
(
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         stall_i,
  input decode_ctrl_t ctrl_i,
  input logic         illegal_i
);

  int unsigned fail_count = 0;

  illegal_is_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    illegal_i |-> (ctrl_i == CTRL_BUBBLE))
    else
    begin
      fail_count++;
      $error("illegal instruction flagged with a non-bubble control word");
    end

  store_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_i.mem_we |-> ctrl_i.mem_req)
    else
    begin
      fail_count++;
      $error("mem_we set without mem_req");
    end

  branch_jal_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ctrl_i.branch && ctrl_i.jal))
    else
    begin
      fail_count++;
      $error("branch and jal both set");
    end

  // Stall sampled at an edge blocks the update at that edge
  stall_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |=> ($stable(ctrl_i) && $stable(illegal_i)))
    else
    begin
      fail_count++;
      $error("outputs changed across a stalled edge");
    end

endmodule

/* testbench/tb_decoder_riscv.sv */
`timescale 1ns/1ps

module tb_decoder_riscv
  import decoder_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int N_LEGAL      = 600;
  localparam int N_ILLEGAL    = 300;
  localparam int N_STALL      = 200;
  localparam int N_IRQ        = 200;
  localparam int N_MIXED      = 1000;
  localparam int TOTAL_CYCLES = 5 + N_LEGAL + N_ILLEGAL + N_STALL + N_IRQ + N_MIXED;

  logic         clk_i;
  logic         rst_n_i;
  logic         stall_i;
  logic         interrupt_i;
  instr_t       instr_i;
  decode_ctrl_t ctrl_o;
  logic         illegal_instr_o;

  decode_ctrl_t exp_ctrl;
  logic         exp_illegal;
  integer       seed = 32'hcb15_7b1e;
  int           check_count = 0;
  int           error_count = 0;

  decoder_riscv DUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_i         (instr_i),
    .stall_i         (stall_i),
    .interrupt_i     (interrupt_i),
    .ctrl_o          (ctrl_o),
    .illegal_instr_o (illegal_instr_o)
  );

  bind decoder_riscv decoder_chk u_chk (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .stall_i   (stall_i),
    .ctrl_i    (ctrl_o),
    .illegal_i (illegal_instr_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("Timeout: the decoder run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    instr_t r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic known_opcode(input opcode_t opc);
    return opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL,
                       OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_SYSTEM, OPC_MISC_MEM};
  endfunction

  // RV32I arithmetic funct3 table
  function automatic alu_op_e alu_for_funct3(input funct3_t f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLTS;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic decode_ctrl_t expected_decode(input instr_t ins, input logic irq,
                                                   output logic ill);
    decode_ctrl_t c;
    funct3_t      f3;
    funct7_t      f7;
    c   = '0;
    ill = 1'b0;
    f3  = ins[14:12];
    f7  = ins[31:25];
    if (irq)
    begin
      c.csr      = 1'b1;  // Trap word
      c.csr_op   = CSR_OP_TRAP;
      c.jalr_sel = JALR_TRAP;
      return c;
    end
    if (ins[1:0] != 2'b11)
      ill = 1'b1;
    else
    begin
      case (ins[6:2])
        OPC_OP:
        begin
          ill      = !(f7 == FUNCT7_BASE || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
          c.alu_op = alu_for_funct3(f3, f7 == FUNCT7_ALT);
          c.gpr_we = 1'b1;
        end
        OPC_OP_IMM:
        begin
          if (f3 == 3'd1)
            ill = (f7 != FUNCT7_BASE);
          else if (f3 == 3'd5)
            ill = !(f7 == FUNCT7_BASE || f7 == FUNCT7_ALT);
          c.op_b_sel = OP_B_IMM_I;
          c.alu_op   = alu_for_funct3(f3, f3 == 3'd5 && f7 == FUNCT7_ALT);
          c.gpr_we   = 1'b1;
        end
        OPC_LOAD:
        begin
          ill          = f3 inside {3'd3, 3'd6, 3'd7};
          c.op_b_sel   = OP_B_IMM_I;
          c.mem_req    = 1'b1;
          c.mem_size   = mem_size_e'(f3);
          c.wb_src_sel = 1'b1;
          c.gpr_we     = 1'b1;
        end
        OPC_STORE:
        begin
          ill        = (f3 > 3'd2);
          c.op_b_sel = OP_B_IMM_S;
          c.mem_req  = 1'b1;
          c.mem_we   = 1'b1;
          c.mem_size = mem_size_e'(f3);
        end
        OPC_BRANCH:
        begin
          c.branch = 1'b1;
          case (f3)
            3'd0:    c.alu_op = ALU_EQ;
            3'd1:    c.alu_op = ALU_NE;
            3'd4:    c.alu_op = ALU_LTS;
            3'd5:    c.alu_op = ALU_GES;
            3'd6:    c.alu_op = ALU_LTU;
            3'd7:    c.alu_op = ALU_GEU;
            default: ill = 1'b1;
          endcase
        end
        OPC_JAL, OPC_JALR:
        begin
          ill        = (ins[6:2] == OPC_JALR) && (f3 != 3'd0);
          c.op_a_sel = OP_A_PC;
          c.op_b_sel = OP_B_INCR4;
          c.jal      = (ins[6:2] == OPC_JAL);
          c.jalr_sel = (ins[6:2] == OPC_JALR) ? JALR_JALR : JALR_NONE;
          c.gpr_we   = 1'b1;
        end
        OPC_LUI, OPC_AUIPC:
        begin
          c.op_a_sel = (ins[6:2] == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
          c.op_b_sel = OP_B_IMM_U;
          c.gpr_we   = 1'b1;
        end
        OPC_SYSTEM:
        begin
          if (f3 == 3'd0)
          begin
            c.jalr_sel = JALR_MRET;
            c.int_rst  = 1'b1;
          end
          else if (f3 <= 3'd3)
          begin
            c.csr    = 1'b1;
            c.csr_op = f3;
            c.gpr_we = 1'b1;
          end
          else
            ill = 1'b1;
        end
        OPC_MISC_MEM: c = '0;  // FENCE does nothing here
        default:      ill = 1'b1;
      endcase
    end
    if (ill)
      c = '0;
    return c;
  endfunction

  function automatic instr_t legal_instr();
    instr_t      r;
    funct3_t     f3;
    funct7_t     f7;
    opcode_t     opc;
    int unsigned k;
    r   = $random(seed);
    f3  = r[14:12];
    f7  = r[31:25];
    opc = OPC_OP;
    case (rand_below(11))
      0: f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[0]) ? FUNCT7_ALT : FUNCT7_BASE;
      1:
      begin
        opc = OPC_OP_IMM;
        if (f3 == 3'd1)
          f7 = FUNCT7_BASE;
        else if (f3 == 3'd5)
          f7 = r[0] ? FUNCT7_ALT : FUNCT7_BASE;
      end
      2:
      begin
        opc = OPC_LOAD;
        k   = rand_below(5);
        f3  = funct3_t'(k < 3 ? k : k + 1);
      end
      3:
      begin
        opc = OPC_STORE;
        f3  = funct3_t'(rand_below(3));
      end
      4:
      begin
        opc = OPC_BRANCH;
        k   = rand_below(6);
        f3  = funct3_t'(k < 2 ? k : k + 2);  // Skip 2 and 3
      end
      5: opc = OPC_JAL;
      6:
      begin
        opc = OPC_JALR;
        f3  = 3'd0;
      end
      7: opc = OPC_LUI;
      8: opc = OPC_AUIPC;
      9:
      begin
        opc = OPC_SYSTEM;
        f3  = funct3_t'(rand_below(4));
      end
      default: opc = OPC_MISC_MEM;
    endcase
    return {f7, r[24:15], f3, r[11:7], opc, QUADRANT_32};
  endfunction

  function automatic instr_t illegal_instr();
    instr_t      r;
    funct3_t     f3;
    funct7_t     f7;
    opcode_t     opc;
    int unsigned k;
    r   = $random(seed);
    f3  = r[14:12];
    f7  = r[31:25];
    opc = OPC_OP;
    case (rand_below(9))
      0:
      begin
        r[1:0] = 2'(rand_below(3));  // Compressed quadrants
        return r;
      end
      1:
      begin
        opc = opcode_t'(rand_below(32));
        while (known_opcode(opc))
          opc = opcode_t'(rand_below(32));
      end
      2: f7 = (r[0] && f3 != 3'd0 && f3 != 3'd5) ? FUNCT7_ALT : (f7 | 7'd1);
      3:
      begin
        opc = OPC_OP_IMM;
        f3  = r[0] ? 3'd5 : 3'd1;
        f7  = f7 | 7'd1;
      end
      4:
      begin
        opc = OPC_LOAD;
        k   = rand_below(3);
        f3  = funct3_t'(k == 0 ? 3 : k + 5);
      end
      5:
      begin
        opc = OPC_STORE;
        f3  = funct3_t'(3 + rand_below(5));
      end
      6:
      begin
        opc = OPC_BRANCH;
        f3  = funct3_t'(2 + rand_below(2));
      end
      7:
      begin
        opc = OPC_JALR;
        f3  = funct3_t'(1 + rand_below(7));
      end
      default:
      begin
        opc = OPC_SYSTEM;
        f3  = funct3_t'(4 + rand_below(4));  // CSR immediate forms
      end
    endcase
    return {f7, r[24:15], f3, r[11:7], opc, QUADRANT_32};
  endfunction

  task automatic check_ctrl(input decode_ctrl_t got, input decode_ctrl_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t: ctrl_o is %h, model expects %h", $time, got, exp);
    end
  endtask

  task automatic check_illegal(input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t: illegal_instr_o is %b, model expects %b", $time, got, exp);
    end
  endtask

  // Drive one cycle and check after the edge
  task automatic step(input instr_t ins, input logic st, input logic irq);
    decode_ctrl_t m_ctrl;
    logic         m_ill;
    instr_i     = ins;
    stall_i     = st;
    interrupt_i = irq;
    m_ctrl      = expected_decode(ins, irq, m_ill);
    @(posedge clk_i);
    #1;
    if (!st)
    begin
      exp_ctrl    = m_ctrl;
      exp_illegal = m_ill;
    end
    check_ctrl(ctrl_o, exp_ctrl);
    check_illegal(illegal_instr_o, exp_illegal);
  endtask

  task automatic random_step(input int unsigned stall_pct, input int unsigned irq_pct,
                             input int unsigned bad_pct);
    instr_t ins;
    logic   st;
    logic   irq;
    ins = (rand_below(100) < bad_pct) ? illegal_instr() : legal_instr();
    st  = (rand_below(100) < stall_pct);
    irq = (rand_below(100) < irq_pct);
    step(ins, st, irq);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d mismatches", name, error_count - errs_before);
  endtask

  initial
  begin
    int errs;
    rst_n_i     = 1'b0;
    stall_i     = 1'b0;
    interrupt_i = 1'b0;
    instr_i     = '0;
    exp_ctrl    = CTRL_BUBBLE;
    exp_illegal = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    errs    = error_count;
    step(illegal_instr(), 1'b1, 1'b1);  // Stalled edge keeps the reset bubble
    report_test("reset bubble", errs);
    errs = error_count;
    repeat (N_LEGAL) random_step(0, 0, 0);
    report_test("legal instructions", errs);
    errs = error_count;
    repeat (N_ILLEGAL) random_step(0, 0, 100);
    report_test("illegal encodings", errs);
    errs = error_count;
    repeat (N_STALL) random_step(50, 30, 30);
    report_test("stall hold", errs);
    errs = error_count;
    repeat (N_IRQ) random_step(0, 50, 30);
    report_test("interrupt override", errs);
    errs = error_count;
    repeat (N_MIXED) random_step(25, 12, 30);
    report_test("mixed stream", errs);
    $display("checks passed: %0d, checks failed: %0d, assertion failures: %0d",
             check_count - error_count, error_count, DUT.u_chk.fail_count);
    if (error_count == 0 && DUT.u_chk.fail_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
